//--- tb.f
source/hood_pkg.sv
source/second_tick.sv
source/hood_timekeeper.sv
source/power_key_window.sv
source/hood_settings.sv
source/hood_fsm.sv
source/hood_top.sv
sim/hood_tb.sv

//--- run.sh
#!/bin/sh
# build the hood testbench with Verilator, run it, decide on the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module hood_tb -f tb.f -o hood_sim
./obj_dir/hood_sim | tee sim.log

if grep -q '^=== PASS ===$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sim/hood_tb.sv
module hood_tb
    import hood_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CPS            = 20;    // clock cycles per second tick
    localparam int TIMEOUT_CYCLES = 20000; // clean 3600 + storm 1200 + edits ~1500, plus margin

    logic          clk;
    logic          rst;
    hood_keys_t    keys;
    hood_state_t   state;
    hood_display_t display;

    logic [31:0]   lcg_state = 32'ha398_c177;
    int            errors    = 0;
    int            cycles    = 0;
    event          settle; // fires when outputs are compared

    // reference model, one register per observable quantity
    int            sec_cnt;
    logic          model_tick;
    hood_state_t   model_state;
    hood_state_t   model_prev; // for storm / clean entry
    hood_state_t   want_next;  // state the pressed key should lead to
    bcd_time_t     model_now;
    bcd_time_t     model_work;
    bcd_time_t     model_cd;
    logic          model_cd_done;
    bcd_time_t     model_switch;
    bcd_time_t     model_remind;
    hood_display_t model_display;

    hood_top #(.CYCLES_PER_SEC(CPS)) hood_top_i (
        .clk    (clk),
        .rst    (rst),
        .keys   (keys),
        .state  (state),
        .display(display)
    );

    always #4 clk = ~clk; // 8 ns period

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 16) % n; // upper bits, low ones cycle short
    endfunction

    // expected display word for a state and the current times
    function automatic hood_display_t expect_display(input hood_state_t s,
            input bcd_time_t now_t, input bcd_time_t work_t, input bcd_time_t cd_t,
            input bcd_time_t sw_t, input bcd_time_t rem_t);
        hood_display_t d;
        case (s)
            SEARCH_WORK:
                d = '{value: work_t, tag: TAG_WORK};
            SEARCH_SWITCH, SET_SWITCH_HOUR, SET_SWITCH_MIN, SET_SWITCH_SEC:
                d = '{value: sw_t, tag: TAG_SWITCH};
            SEARCH_REMIND, SET_REMIND_HOUR, SET_REMIND_MIN, SET_REMIND_SEC:
                d = '{value: rem_t, tag: TAG_REMIND};
            STORM, CLEAN:
                d = '{value: cd_t, tag: TAG_COUNTDOWN};
            default:
                d = '{value: now_t, tag: TAG_NOW}; // clock of day
        endcase
        return d;
    endfunction

    // cycle model of times, settings and expected state
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            sec_cnt       <= 0;
            model_tick    <= 1'b0;
            model_state   <= SHUTDOWN;
            model_prev    <= SHUTDOWN;
            model_now     <= '0;
            model_work    <= '0;
            model_cd      <= '0;
            model_cd_done <= 1'b0;
            model_switch  <= DEFAULT_SWITCH_TIME;
            model_remind  <= DEFAULT_REMIND_TIME;
            model_display <= '{value: '0, tag: TAG_NOW};
        end else begin
            model_tick <= (sec_cnt == CPS - 1); // own second count
            sec_cnt    <= (sec_cnt == CPS - 1) ? 0 : sec_cnt + 1;

            if (keys != '0)
                model_state <= want_next;
            else if (model_cd_done && model_state == STORM)
                model_state <= GEAR_TWO; // storm runs out into gear two
            else if (model_cd_done && model_state == CLEAN)
                model_state <= STANDBY;

            if (model_state == SHUTDOWN) begin
                model_now  <= '0;
                model_work <= '0;
            end else if (model_tick) begin
                model_now <= bcd_time_next(model_now);
                if (model_state inside {GEAR_ONE, GEAR_TWO, STORM})
                    model_work <= bcd_time_next(model_work); // fan running
            end

            model_prev    <= model_state;
            model_cd_done <= 1'b0;
            if (model_state == STORM && model_prev != STORM)
                model_cd <= STORM_TIME;
            else if (model_state == CLEAN && model_prev != CLEAN)
                model_cd <= CLEAN_TIME;
            else if (model_tick && model_cd != '0) begin
                model_cd      <= bcd_time_prev(model_cd);
                model_cd_done <= (model_cd == 24'h00_00_01); // last second gone
            end

            if (model_state == SHUTDOWN) begin
                model_switch <= DEFAULT_SWITCH_TIME;
                model_remind <= DEFAULT_REMIND_TIME;
            end else if (keys.a) begin
                case (model_state)
                    SET_SWITCH_HOUR: model_switch <= bcd_field_inc(model_switch, FIELD_HOUR);
                    SET_SWITCH_MIN:  model_switch <= bcd_field_inc(model_switch, FIELD_MIN);
                    SET_SWITCH_SEC:  model_switch <= bcd_field_inc(model_switch, FIELD_SEC);
                    SET_REMIND_HOUR: model_remind <= bcd_field_inc(model_remind, FIELD_HOUR);
                    SET_REMIND_MIN:  model_remind <= bcd_field_inc(model_remind, FIELD_MIN);
                    SET_REMIND_SEC:  model_remind <= bcd_field_inc(model_remind, FIELD_SEC);
                    default: ;
                endcase
            end

            model_display <= expect_display(model_state, model_now, model_work, model_cd,
                                            model_switch, model_remind); // one cycle behind
        end
    end

    // compares DUT outputs with the model
    always @(settle) begin
        if (state !== model_state) begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t state: expected %s actual %s",
                     $time, model_state.name(), state.name());
        end
        if (display !== model_display) begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t display: expected %h actual %h",
                     $time, model_display, display);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, %0d errors so far", cycles, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic settle_check();
        repeat (3) @(posedge clk);
        @(negedge clk); // outputs stable here
        -> settle;
    endtask

    task automatic press_key(input byte k, input hood_state_t want);
        hood_keys_t strobe;
        strobe = '0;
        case (k)
            "a": strobe.a = 1'b1;
            "s": strobe.s = 1'b1;
            "d": strobe.d = 1'b1;
            "w": strobe.w = 1'b1;
            "x": strobe.x = 1'b1;
            default: ;
        endcase
        repeat (rand_below(4)) @(posedge clk); // idle gap, shifts tick phase
        @(posedge clk);
        keys      <= strobe;
        want_next <= want;
        @(posedge clk);
        keys <= '0; // one cycle strobe
        settle_check();
    endtask

    // counts model ticks, one per second
    task automatic wait_seconds(input int n);
        repeat (n) begin
            @(negedge clk);
            while (!model_tick)
                @(negedge clk);
        end
    endtask

    // countdown end, compared on the exact cycle and after settling
    task automatic wait_state(input hood_state_t s);
        while (state !== s)
            @(negedge clk);
        -> settle;
        settle_check();
    endtask

    task automatic edit_value(input hood_state_t view, input hood_state_t hour_st,
                              input hood_state_t min_st, input hood_state_t sec_st);
        press_key("x", hour_st);
        repeat (rand_below(31)) press_key("a", hour_st);
        press_key("s", min_st);
        repeat (1 + rand_below(30)) press_key("a", min_st); // minutes never end at 00
        press_key("s", sec_st);
        repeat (rand_below(31)) press_key("a", sec_st);
        press_key("s", view);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        keys      = '0;
        want_next = SHUTDOWN;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        settle_check(); // reset values

        // power-on pairing
        press_key("d", SHUTDOWN); // lone d
        press_key("a", SHUTDOWN);
        wait_seconds(6);          // window of 5 s runs out
        press_key("d", SHUTDOWN);
        press_key("a", SHUTDOWN);
        press_key("d", STANDBY);

        // gears and work time
        press_key("w", MENU);
        press_key("a", GEAR_ONE);
        wait_seconds(1 + rand_below(6));
        press_key("s", GEAR_TWO);
        wait_seconds(1 + rand_below(6));
        press_key("w", STANDBY);
        press_key("x", SEARCH);
        press_key("a", SEARCH_WORK);
        press_key("w", SEARCH);
        press_key("w", STANDBY);

        // storm, once per power-on
        press_key("w", MENU);
        press_key("d", STORM);
        wait_state(GEAR_TWO);
        press_key("w", STANDBY);
        press_key("w", MENU);
        press_key("d", MENU);

        // self-clean
        press_key("x", CLEAN);
        wait_state(STANDBY);

        // field editing on both values
        press_key("x", SEARCH);
        press_key("s", SEARCH_SWITCH);
        edit_value(SEARCH_SWITCH, SET_SWITCH_HOUR, SET_SWITCH_MIN, SET_SWITCH_SEC);
        press_key("w", SEARCH);
        press_key("d", SEARCH_REMIND);
        edit_value(SEARCH_REMIND, SET_REMIND_HOUR, SET_REMIND_MIN, SET_REMIND_SEC);
        press_key("w", SEARCH);
        press_key("w", STANDBY);

        // power off under the edited window, then defaults after power-on
        press_key("d", STANDBY);
        wait_seconds(2);
        press_key("a", SHUTDOWN);
        press_key("a", SHUTDOWN);
        press_key("d", STANDBY);
        press_key("x", SEARCH);
        press_key("s", SEARCH_SWITCH);
        press_key("w", SEARCH);
        press_key("d", SEARCH_REMIND);

        @(posedge clk); // let the last compare finish
        $display("checks done, %0d errors", errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- source/hood_top.sv
module hood_top
    import hood_pkg::*;
#(
    parameter int unsigned CYCLES_PER_SEC = 100000000
) (
    input  logic          clk,
    input  logic          rst,
    input  hood_keys_t    keys, // one-cycle strobes, at most one high
    output hood_state_t   state,
    output hood_display_t display
);

    logic      tick;
    logic      win_arm;
    logic      win_clear;
    logic      win_open;
    logic      cd_done;
    bcd_time_t now_time;
    bcd_time_t work_time;
    bcd_time_t countdown;
    bcd_time_t switch_time; // also the power window length
    bcd_time_t remind_time;

    second_tick #(.CYCLES_PER_SEC(CYCLES_PER_SEC)) second_tick_i (
        .clk (clk),
        .rst (rst),
        .tick(tick)
    );

    hood_timekeeper hood_timekeeper_i (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .state    (state),
        .now_time (now_time),
        .work_time(work_time),
        .countdown(countdown),
        .cd_done  (cd_done)
    );

    power_key_window power_key_window_i (
        .clk  (clk),
        .rst  (rst),
        .tick (tick),
        .arm  (win_arm),
        .clear(win_clear),
        .limit(switch_time),
        .open (win_open)
    );

    hood_settings hood_settings_i (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .keys       (keys),
        .switch_time(switch_time),
        .remind_time(remind_time)
    );

    hood_fsm hood_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .keys       (keys),
        .win_open   (win_open),
        .cd_done    (cd_done),
        .now_time   (now_time),
        .work_time  (work_time),
        .countdown  (countdown),
        .switch_time(switch_time),
        .remind_time(remind_time),
        .state      (state),
        .win_arm    (win_arm),
        .win_clear  (win_clear),
        .display    (display)
    );

endmodule

//--- source/hood_fsm.sv
module hood_fsm
    import hood_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  hood_keys_t    keys,
    input  logic          win_open,
    input  logic          cd_done,
    input  bcd_time_t     now_time,
    input  bcd_time_t     work_time,
    input  bcd_time_t     countdown,
    input  bcd_time_t     switch_time,
    input  bcd_time_t     remind_time,
    output hood_state_t   state,
    output logic          win_arm,
    output logic          win_clear,
    output hood_display_t display
);

    hood_state_t state_next;
    logic        storm_used; // storm allowed once per power-on

    always_comb begin
        state_next = state;
        win_arm    = 1'b0;
        win_clear  = 1'b0;
        case (state)
            SHUTDOWN: begin
                if (keys.a) begin
                    win_arm = 1'b1; // first half of power-on
                end else if (keys.d && win_open) begin
                    state_next = STANDBY;
                    win_clear  = 1'b1;
                end
            end
            STANDBY: begin
                if (keys.a && win_open) begin
                    state_next = SHUTDOWN; // d then a powers off
                    win_clear  = 1'b1;
                end else if (keys.d) begin
                    win_arm = 1'b1;
                end else if (keys.w) begin
                    state_next = MENU;
                end else if (keys.x) begin
                    state_next = SEARCH;
                end
            end
            MENU: begin
                if (keys.a)                    state_next = GEAR_ONE;
                else if (keys.s)               state_next = GEAR_TWO;
                else if (keys.d && !storm_used) state_next = STORM;
                else if (keys.x)               state_next = CLEAN;
            end
            GEAR_ONE: begin
                if (keys.s)      state_next = GEAR_TWO;
                else if (keys.w) state_next = STANDBY;
            end
            GEAR_TWO: if (keys.w) state_next = STANDBY;
            STORM:    if (cd_done) state_next = GEAR_TWO; // storm settles into gear two
            CLEAN:    if (cd_done) state_next = STANDBY;
            SEARCH: begin
                if (keys.a)      state_next = SEARCH_WORK;
                else if (keys.s) state_next = SEARCH_SWITCH;
                else if (keys.d) state_next = SEARCH_REMIND;
                else if (keys.w) state_next = STANDBY;
            end
            SEARCH_WORK: if (keys.w) state_next = SEARCH;
            SEARCH_SWITCH: begin
                if (keys.w)      state_next = SEARCH;
                else if (keys.x) state_next = SET_SWITCH_HOUR;
            end
            SEARCH_REMIND: begin
                if (keys.w)      state_next = SEARCH;
                else if (keys.x) state_next = SET_REMIND_HOUR;
            end
            // s walks hour -> min -> sec -> view, a is taken by hood_settings
            SET_SWITCH_HOUR: if (keys.s) state_next = SET_SWITCH_MIN;
            SET_SWITCH_MIN:  if (keys.s) state_next = SET_SWITCH_SEC;
            SET_SWITCH_SEC:  if (keys.s) state_next = SEARCH_SWITCH;
            SET_REMIND_HOUR: if (keys.s) state_next = SET_REMIND_MIN;
            SET_REMIND_MIN:  if (keys.s) state_next = SET_REMIND_SEC;
            SET_REMIND_SEC:  if (keys.s) state_next = SEARCH_REMIND;
            default: state_next = SHUTDOWN;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= SHUTDOWN;
            storm_used <= 1'b0;
        end else begin
            state <= state_next;
            if (state == SHUTDOWN)
                storm_used <= 1'b0;
            else if (state == STORM)
                storm_used <= 1'b1;
        end
    end

    // registered display word, one cycle behind state
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            display <= '{value: '0, tag: TAG_NOW};
        end else begin
            case (state)
                SEARCH_WORK:
                    display <= '{value: work_time, tag: TAG_WORK};
                SEARCH_SWITCH, SET_SWITCH_HOUR, SET_SWITCH_MIN, SET_SWITCH_SEC:
                    display <= '{value: switch_time, tag: TAG_SWITCH};
                SEARCH_REMIND, SET_REMIND_HOUR, SET_REMIND_MIN, SET_REMIND_SEC:
                    display <= '{value: remind_time, tag: TAG_REMIND};
                STORM, CLEAN:
                    display <= '{value: countdown, tag: TAG_COUNTDOWN};
                default:
                    display <= '{value: now_time, tag: TAG_NOW}; // clock of day
            endcase
        end
    end

endmodule

//--- source/hood_settings.sv
module hood_settings
    import hood_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  hood_state_t state,
    input  hood_keys_t  keys,
    output bcd_time_t   switch_time,
    output bcd_time_t   remind_time
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            switch_time <= DEFAULT_SWITCH_TIME;
            remind_time <= DEFAULT_REMIND_TIME;
        end else if (state == SHUTDOWN) begin
            switch_time <= DEFAULT_SWITCH_TIME; // power-off restores defaults
            remind_time <= DEFAULT_REMIND_TIME;
        end else if (keys.a) begin
            // a bumps the field named by the edit state
            case (state)
                SET_SWITCH_HOUR: switch_time <= bcd_field_inc(switch_time, FIELD_HOUR);
                SET_SWITCH_MIN:  switch_time <= bcd_field_inc(switch_time, FIELD_MIN);
                SET_SWITCH_SEC:  switch_time <= bcd_field_inc(switch_time, FIELD_SEC);
                SET_REMIND_HOUR: remind_time <= bcd_field_inc(remind_time, FIELD_HOUR);
                SET_REMIND_MIN:  remind_time <= bcd_field_inc(remind_time, FIELD_MIN);
                SET_REMIND_SEC:  remind_time <= bcd_field_inc(remind_time, FIELD_SEC);
                default: ; // a means something else here
            endcase
        end
    end

endmodule

//--- source/power_key_window.sv
module power_key_window
    import hood_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      tick,
    input  logic      arm,
    input  logic      clear,
    input  bcd_time_t limit,
    output logic      open
);

    bcd_time_t elapsed; // whole seconds since arm
    bcd_time_t elapsed_next;

    assign elapsed_next = bcd_time_next(elapsed);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            open    <= 1'b0;
            elapsed <= '0;
        end else if (clear) begin
            open <= 1'b0;
        end else if (arm) begin
            open    <= 1'b1; // re-arm restarts the count
            elapsed <= '0;
        end else if (open && tick) begin
            elapsed <= elapsed_next;
            if (elapsed_next >= limit) // bcd digits order like binary
                open <= 1'b0;
        end
    end

endmodule

//--- source/hood_timekeeper.sv
module hood_timekeeper
    import hood_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        tick,
    input  hood_state_t state,
    output bcd_time_t   now_time,
    output bcd_time_t   work_time,
    output bcd_time_t   countdown,
    output logic        cd_done
);

    hood_state_t prev_state; // for entry detect
    logic        fan_on;

    assign fan_on = (state == GEAR_ONE) || (state == GEAR_TWO) || (state == STORM);

    // clock of day and work time
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            now_time  <= '0;
            work_time <= '0;
        end else if (state == SHUTDOWN) begin
            now_time  <= '0; // both held while off
            work_time <= '0;
        end else if (tick) begin
            now_time <= bcd_time_next(now_time);
            if (fan_on)
                work_time <= bcd_time_next(work_time); // only while a gear runs
        end
    end

    // storm / clean countdown
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prev_state <= SHUTDOWN;
            countdown  <= '0;
            cd_done    <= 1'b0;
        end else begin
            prev_state <= state;
            cd_done    <= 1'b0;
            if (state == STORM && prev_state != STORM) begin
                countdown <= STORM_TIME;
            end else if (state == CLEAN && prev_state != CLEAN) begin
                countdown <= CLEAN_TIME;
            end else if (tick && countdown != '0) begin
                countdown <= bcd_time_prev(countdown);
                if (countdown == 24'h00_00_01)
                    cd_done <= 1'b1; // pulses once as the count reaches zero
            end
        end
    end

endmodule

//--- source/second_tick.sv
module second_tick #(
    parameter int unsigned CYCLES_PER_SEC = 100000000
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [$clog2(CYCLES_PER_SEC + 1)-1:0] cnt; // cycles within the current second

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == $bits(cnt)'(CYCLES_PER_SEC - 1)) begin
            cnt  <= '0;
            tick <= 1'b1; // one cycle wide
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

//--- source/hood_pkg.sv
package hood_pkg;

    // state codes follow the old control word, SEARCH moved off the MENU code
    typedef enum logic [6:0] {
        SHUTDOWN        = 7'b000_0000,
        STANDBY         = 7'b100_0000,
        MENU            = 7'b101_0000,
        GEAR_ONE        = 7'b101_0100,
        GEAR_TWO        = 7'b101_1000,
        STORM           = 7'b101_1100,
        CLEAN           = 7'b101_0010,
        SEARCH          = 7'b110_0000, // free code
        SEARCH_WORK     = 7'b110_0100,
        SEARCH_SWITCH   = 7'b110_1000,
        SEARCH_REMIND   = 7'b110_1100,
        SET_SWITCH_HOUR = 7'b111_1001,
        SET_SWITCH_MIN  = 7'b111_1010,
        SET_SWITCH_SEC  = 7'b111_1011,
        SET_REMIND_HOUR = 7'b111_1101,
        SET_REMIND_MIN  = 7'b111_1110,
        SET_REMIND_SEC  = 7'b111_1111
    } hood_state_t;

    typedef struct packed {
        logic [3:0] hour_tens;
        logic [3:0] hour_ones;
        logic [3:0] min_tens;
        logic [3:0] min_ones;
        logic [3:0] sec_tens;
        logic [3:0] sec_ones;
    } bcd_time_t;

    typedef struct packed {
        logic a;
        logic s;
        logic d;
        logic w;
        logic x;
    } hood_keys_t;

    typedef enum logic [7:0] {
        TAG_NOW       = 8'd0,
        TAG_WORK      = 8'd1,
        TAG_SWITCH    = 8'd2,
        TAG_REMIND    = 8'd3,
        TAG_COUNTDOWN = 8'd4
    } display_tag_t;

    typedef struct packed {
        bcd_time_t    value; // upper 24 bits of the display word
        display_tag_t tag;
    } hood_display_t;

    typedef enum logic [1:0] {FIELD_HOUR, FIELD_MIN, FIELD_SEC} bcd_field_t;

    localparam bcd_time_t DEFAULT_SWITCH_TIME = 24'h00_00_05;
    localparam bcd_time_t DEFAULT_REMIND_TIME = 24'h10_00_00;
    localparam bcd_time_t STORM_TIME          = 24'h00_01_00;
    localparam bcd_time_t CLEAN_TIME          = 24'h00_03_00;

    // two-digit bcd step up, wraps max -> 00
    function automatic logic [7:0] bcd2_inc(input logic [3:0] tens, input logic [3:0] ones,
                                            input logic [7:0] max);
        if ({tens, ones} == max) return 8'h00;
        if (ones == 4'd9) return {tens + 4'd1, 4'd0}; // carry into tens
        return {tens, ones + 4'd1};
    endfunction

    // two-digit bcd step down, 00 -> max
    function automatic logic [7:0] bcd2_dec(input logic [3:0] tens, input logic [3:0] ones,
                                            input logic [7:0] max);
        if ({tens, ones} == 8'h00) return max;
        if (ones == 4'd0) return {tens - 4'd1, 4'd9}; // borrow from tens
        return {tens, ones - 4'd1};
    endfunction

    function automatic bcd_time_t bcd_time_next(input bcd_time_t t);
        bcd_time_t r;
        r = t;
        {r.sec_tens, r.sec_ones} = bcd2_inc(t.sec_tens, t.sec_ones, 8'h59);
        if ({t.sec_tens, t.sec_ones} == 8'h59) begin
            {r.min_tens, r.min_ones} = bcd2_inc(t.min_tens, t.min_ones, 8'h59);
            if ({t.min_tens, t.min_ones} == 8'h59)
                {r.hour_tens, r.hour_ones} = bcd2_inc(t.hour_tens, t.hour_ones, 8'h23);
        end
        return r;
    endfunction

    function automatic bcd_time_t bcd_time_prev(input bcd_time_t t);
        bcd_time_t r;
        r = t;
        if (t == '0) return t; // holds at zero
        {r.sec_tens, r.sec_ones} = bcd2_dec(t.sec_tens, t.sec_ones, 8'h59);
        if ({t.sec_tens, t.sec_ones} == 8'h00) begin
            {r.min_tens, r.min_ones} = bcd2_dec(t.min_tens, t.min_ones, 8'h59);
            if ({t.min_tens, t.min_ones} == 8'h00) // hour nonzero here
                {r.hour_tens, r.hour_ones} = bcd2_dec(t.hour_tens, t.hour_ones, 8'h23);
        end
        return r;
    endfunction

    function automatic bcd_time_t bcd_field_inc(input bcd_time_t t, input bcd_field_t f);
        bcd_time_t r;
        r = t;
        case (f)
            FIELD_HOUR: {r.hour_tens, r.hour_ones} = bcd2_inc(t.hour_tens, t.hour_ones, 8'h23);
            FIELD_MIN:  {r.min_tens, r.min_ones} = bcd2_inc(t.min_tens, t.min_ones, 8'h59);
            default:    {r.sec_tens, r.sec_ones} = bcd2_inc(t.sec_tens, t.sec_ones, 8'h59);
        endcase
        return r;
    endfunction

endpackage
